// ==== sim.f ====
+incdir+.
mic1_pkg.sv
synchronizer.sv
debouncer.sv
run_control.sv
program_rom.sv
stack_core.sv
mic1_board.sv
tb_mic1_board.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -j 0 --top-module tb_mic1_board -f sim.f -o sim_tb
./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "Simulation PASSED"
    exit 0
else
    echo "Simulation FAILED"
    exit 1
fi

// ==== tb_mic1_board.sv ====
`timescale 1ns/1ps

module tb_mic1_board
    import mic1_pkg::*;
();

    localparam int CLK_HALF    = 20;
    localparam int DRIVE_DLY   = 2;
    localparam int HOLD_CYCLES = 20;
    localparam int RST_CYCLES  = 5;
    localparam int BTN_RUN     = 0;
    localparam int BTN_STEP    = 1;
    localparam int BTN_STOP    = 2;

    typedef enum logic [1:0] {
        ACT_STEP,
        ACT_RUN,
        ACT_RESET,
        ACT_RUN_STOP
    } action_t;

    typedef struct packed {
        action_t act;
        logic    check_out; // Word not predictable after a stopped run
        word_t   out;
        logic    halted;
        logic    led_run;
    } entry_t;

    logic   clk;
    logic   resetn;
    logic   btn_run;
    logic   btn_step;
    logic   btn_stop;
    logic   led_idle;
    logic   led_run;
    logic   led1;
    logic   led2;
    logic   led3;
    logic   led4;
    logic   led5;
    word_t  out_word;
    logic   halted;
    int     seed;
    entry_t table_q[$];

    mic1_board #(.DEBOUNCE_COUNT(4)) UUT (
        .clk      (clk),
        .resetn   (resetn),
        .btn_run  (btn_run),
        .btn_step (btn_step),
        .btn_stop (btn_stop),
        .led_idle (led_idle),
        .led_run  (led_run),
        .led1     (led1),
        .led2     (led2),
        .led3     (led3),
        .led4     (led4),
        .led5     (led5),
        .out_word (out_word),
        .halted   (halted)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    function automatic string state_text(input run_state_t s);
        case (s)
            IDLE:    return "IDLE";
            RUN:     return "RUN";
            STEP:    return "STEP";
            default: return "unknown";
        endcase
    endfunction

    function automatic void add_entry(input action_t act, input logic check_out,
                                      input word_t exp_out, input logic exp_halted,
                                      input logic exp_led_run);
        table_q.push_back('{act, check_out, exp_out, exp_halted, exp_led_run});
    endfunction

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            $display("Test failed");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %b, expected %b, controller in %s",
                     $time, name, got, exp, state_text(UUT.u_run_control.state));
            $display("Test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_outputs(input entry_t e);
        if (e.check_out) begin
            check_word(out_word, e.out, "out_word");
            check_bit(led1, e.out[0], "led1");
            check_bit(led2, e.out[1], "led2");
            check_bit(led3, e.out[2], "led3");
            check_bit(led4, e.out[31], "led4");
            check_bit(led5, |e.out, "led5");
        end
        check_bit(halted, e.halted, "halted");
        check_bit(led_run, e.led_run, "led_run");
        check_bit(led_idle, ~e.led_run, "led_idle");
    endtask

    task automatic drive_edge();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic set_button(input int which, input logic level);
        case (which)
            BTN_RUN:  btn_run = level;
            BTN_STEP: btn_step = level;
            BTN_STOP: btn_stop = level;
            default:  ;
        endcase
    endtask

    task automatic press_button(input int which);
        drive_edge();
        set_button(which, 1'b1);
        repeat (HOLD_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        set_button(which, 1'b0);
        repeat (HOLD_CYCLES) @(posedge clk);
    endtask

    // Run pressed while stop is held, so the core never reaches HALT
    task automatic run_then_stop();
        drive_edge();
        set_button(BTN_STOP, 1'b1);
        repeat (10) @(posedge clk);
        #DRIVE_DLY;
        set_button(BTN_RUN, 1'b1);
        repeat (8) @(posedge clk);
        #DRIVE_DLY;
        set_button(BTN_RUN, 1'b0);
        repeat (12) @(posedge clk); // Run level gone, stop still high
        #DRIVE_DLY;
        set_button(BTN_STOP, 1'b0);
        repeat (12) @(posedge clk);
    endtask

    task automatic apply_reset();
        drive_edge();
        resetn = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        resetn = 1'b1;
    endtask

    initial begin
        int limit;
        #1; // Table is built at time zero
        limit = table_q.size() * 60 + 200;
        repeat (limit) @(posedge clk);
        $display("Simulation timed out before the stimulus table was finished");
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        entry_t e;
        int     gap;
        seed     = 32'hec7b6cca;
        resetn   = 1'b0;
        btn_run  = 1'b0;
        btn_step = 1'b0;
        btn_stop = 1'b0;

        add_entry(ACT_RESET, 1'b1, 0, 1'b0, 1'b0);
        add_entry(ACT_STEP, 1'b1, 0, 1'b0, 1'b0);
        add_entry(ACT_STEP, 1'b1, 0, 1'b0, 1'b0);
        add_entry(ACT_STEP, 1'b1, 0, 1'b0, 1'b0);
        add_entry(ACT_STEP, 1'b1, 8, 1'b0, 1'b0);   // First OUT
        add_entry(ACT_STEP, 1'b1, 8, 1'b0, 1'b0);
        add_entry(ACT_STEP, 1'b1, 8, 1'b0, 1'b0);
        add_entry(ACT_STEP, 1'b1, 16, 1'b0, 1'b0);
        add_entry(ACT_STEP, 1'b1, 16, 1'b0, 1'b0);
        add_entry(ACT_STEP, 1'b1, 16, 1'b0, 1'b0);
        add_entry(ACT_STEP, 1'b1, 15, 1'b0, 1'b0);
        add_entry(ACT_RUN, 1'b1, -5, 1'b1, 1'b0);   // Halt drops led_run
        add_entry(ACT_STEP, 1'b1, -5, 1'b1, 1'b0);
        add_entry(ACT_RUN, 1'b1, -5, 1'b1, 1'b0);
        add_entry(ACT_RESET, 1'b1, 0, 1'b0, 1'b0);
        add_entry(ACT_RUN_STOP, 1'b0, 0, 1'b0, 1'b0);
        add_entry(ACT_RUN, 1'b1, -5, 1'b1, 1'b0);

        foreach (table_q[i]) begin
            e = table_q[i];
            case (e.act)
                ACT_STEP:  press_button(BTN_STEP);
                ACT_RUN:   press_button(BTN_RUN);
                ACT_RESET: apply_reset();
                default:   run_then_stop();
            endcase
            @(negedge clk);
            check_outputs(e);
            gap = $unsigned($random(seed)) % 16;
            repeat (gap) @(posedge clk);
            @(negedge clk);
            check_outputs(e); // Idle outputs must hold
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== mic1_board.sv ====
`timescale 1ns/1ps

`include "mic1_cfg.svh"

module mic1_board
    import mic1_pkg::*;
#(
    parameter int DEBOUNCE_COUNT = `DEBOUNCE_COUNT
) (
    input  logic  clk,
    input  logic  resetn,
    input  logic  btn_run,
    input  logic  btn_step,
    input  logic  btn_stop,
    output logic  led_idle,
    output logic  led_run,
    output logic  led1,
    output logic  led2,
    output logic  led3,
    output logic  led4,
    output logic  led5,
    output word_t out_word,
    output logic  halted
);

    logic [2:0] btn;
    logic [2:0] btn_sync;
    logic [2:0] btn_level; // {stop, step, run}
    logic       core_run;
    logic [3:0] rom_addr;
    instr_t     rom_data;

    assign btn = {btn_stop, btn_step, btn_run};

    // Same conditioning chain for each button
    for (genvar i = 0; i < 3; i++) begin : g_btn
        synchronizer u_sync (
            .clk    (clk),
            .resetn (resetn),
            .in     (btn[i]),
            .out    (btn_sync[i])
        );

        debouncer #(.MAX_COUNT(DEBOUNCE_COUNT)) u_debounce (
            .clk    (clk),
            .resetn (resetn),
            .in     (btn_sync[i]),
            .out    (btn_level[i])
        );
    end

    run_control u_run_control (
        .clk         (clk),
        .resetn      (resetn),
        .run_level   (btn_level[0]),
        .step_level  (btn_level[1]),
        .stop_level  (btn_level[2]),
        .core_halted (halted),
        .core_run    (core_run),
        .led_run     (led_run),
        .led_idle    (led_idle)
    );

    program_rom u_rom (
        .rom_addr (rom_addr),
        .rom_data (rom_data)
    );

    stack_core u_core (
        .clk      (clk),
        .resetn   (resetn),
        .run      (core_run),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .out_word (out_word),
        .halted   (halted)
    );

    assign led1 = out_word[0];
    assign led2 = out_word[1];
    assign led3 = out_word[2];
    assign led4 = out_word[31]; // Sign
    assign led5 = |out_word;

endmodule

// ==== stack_core.sv ====
`timescale 1ns/1ps

`include "mic1_cfg.svh"

module stack_core
    import mic1_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  logic       run,
    output logic [3:0] rom_addr,
    input  instr_t     rom_data,
    output word_t      out_word,
    output logic       halted
);

    localparam int PC_W = $clog2(`ROM_DEPTH);
    localparam int SP_W = $clog2(`STACK_DEPTH);

    logic [PC_W-1:0] pc;
    logic [PC_W-1:0] pc_nxt;
    logic [SP_W-1:0] sp;     // Next free entry
    logic [SP_W-1:0] sp_nxt;
    logic [SP_W-1:0] sp_p1;
    logic [SP_W-1:0] sp_m1;
    logic [SP_W-1:0] sp_m2;

    word_t stack [`STACK_DEPTH];
    word_t tos;
    word_t nos;
    word_t imm_ext;
    word_t out_nxt;
    word_t wr_data;

    logic [SP_W-1:0] wr_ptr;
    logic            wr_en;
    logic            halt_nxt;
    logic            exec;

    opcode_t    op;
    logic [7:0] imm;

    assign rom_addr = pc;
    assign op       = opcode_t'(rom_data[15:8]);
    assign imm      = rom_data[7:0];
    assign imm_ext  = {{24{imm[7]}}, imm};

    assign sp_p1 = sp + 1'b1;
    assign sp_m1 = sp - 1'b1;
    assign sp_m2 = sp - 2'd2;
    assign tos   = stack[sp_m1];
    assign nos   = stack[sp_m2];

    assign exec = run && !halted;

    always_comb begin
        pc_nxt   = pc + 1'b1;
        sp_nxt   = sp;
        out_nxt  = out_word;
        halt_nxt = 1'b0;
        wr_en    = 1'b0;
        wr_ptr   = sp;
        wr_data  = imm_ext;
        case (op)
            OP_BIPUSH: begin
                wr_en  = 1'b1;
                sp_nxt = sp_p1;
            end
            OP_IADD: begin
                wr_en   = 1'b1;
                wr_ptr  = sp_m2; // Result replaces a
                wr_data = nos + tos;
                sp_nxt  = sp_m1;
            end
            OP_ISUB: begin
                wr_en   = 1'b1;
                wr_ptr  = sp_m2;
                wr_data = nos - tos;
                sp_nxt  = sp_m1;
            end
            OP_DUP: begin
                wr_en   = 1'b1;
                wr_data = tos;
                sp_nxt  = sp_p1;
            end
            OP_POP:  sp_nxt = sp_m1;
            OP_OUT:  out_nxt = tos;
            OP_GOTO: pc_nxt = imm[PC_W-1:0];
            OP_HALT: begin
                pc_nxt   = pc; // Park on the HALT word
                halt_nxt = 1'b1;
            end
            default: ; // Unknown opcodes act as NOP
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc       <= '0;
            sp       <= '0;
            out_word <= '0;
            halted   <= 1'b0;
        end else if (exec) begin
            pc       <= pc_nxt;
            sp       <= sp_nxt;
            out_word <= out_nxt;
            halted   <= halt_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (resetn && exec && wr_en) begin
            stack[wr_ptr] <= wr_data;
        end
    end

endmodule

// ==== program_rom.sv ====
`timescale 1ns/1ps

module program_rom
    import mic1_pkg::*;
(
    input  logic [3:0] rom_addr,
    output instr_t     rom_data
);

    function automatic instr_t ins(opcode_t op, logic [7:0] imm);
        return {op, imm};
    endfunction

    // Demo: ((5 + 3) * 2 - 1) - 20
    always_comb begin
        case (rom_addr)
            4'd0:    rom_data = ins(OP_BIPUSH, 8'd5);
            4'd1:    rom_data = ins(OP_BIPUSH, 8'd3);
            4'd2:    rom_data = ins(OP_IADD, 8'd0);
            4'd3:    rom_data = ins(OP_OUT, 8'd0);    // 8
            4'd4:    rom_data = ins(OP_DUP, 8'd0);
            4'd5:    rom_data = ins(OP_IADD, 8'd0);
            4'd6:    rom_data = ins(OP_OUT, 8'd0);    // 16
            4'd7:    rom_data = ins(OP_BIPUSH, 8'd1);
            4'd8:    rom_data = ins(OP_ISUB, 8'd0);
            4'd9:    rom_data = ins(OP_OUT, 8'd0);    // 15
            4'd10:   rom_data = ins(OP_BIPUSH, 8'hEC); // -20
            4'd11:   rom_data = ins(OP_IADD, 8'd0);
            4'd12:   rom_data = ins(OP_OUT, 8'd0);    // -5
            4'd13:   rom_data = ins(OP_HALT, 8'd0);
            default: rom_data = ins(OP_NOP, 8'd0);
        endcase
    end

endmodule

// ==== run_control.sv ====
`timescale 1ns/1ps

module run_control
    import mic1_pkg::*;
(
    input  logic clk,
    input  logic resetn,
    input  logic run_level,
    input  logic step_level,
    input  logic stop_level,
    input  logic core_halted,
    output logic core_run,
    output logic led_run,
    output logic led_idle
);

    run_state_t state;
    run_state_t next_state;
    logic       step_d;
    logic       step_edge;

    assign step_edge = step_level & ~step_d;

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                // A halted core cannot be restarted
                if (run_level && !core_halted) begin
                    next_state = RUN;
                end
                if (step_edge) begin
                    next_state = STEP;
                end
            end
            RUN: begin
                if (stop_level || core_halted) begin
                    next_state = IDLE;
                end
            end
            STEP:    next_state = IDLE; // One instruction only
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state  <= IDLE;
            step_d <= 1'b0;
        end else begin
            state  <= next_state;
            step_d <= step_level;
        end
    end

    assign core_run = (state == RUN) || (state == STEP);
    assign led_run  = core_run;
    assign led_idle = ~core_run;

endmodule

// ==== debouncer.sv ====
`timescale 1ns/1ps

`include "mic1_cfg.svh"

module debouncer #(
    parameter int MAX_COUNT = `DEBOUNCE_COUNT
) (
    input  logic clk,
    input  logic resetn,
    input  logic in,
    output logic out
);

    localparam int CNT_W = $clog2(MAX_COUNT + 1);

    logic [CNT_W-1:0] count;
    logic             count_done;

    assign count_done = (count == CNT_W'(MAX_COUNT));

    // Input differing from out is the candidate level
    always_ff @(posedge clk) begin
        if (!resetn) begin
            count <= '0;
            out   <= 1'b0;
        end else if (in == out) begin
            count <= '0; // Bounce back, start over
        end else if (count_done) begin
            count <= '0;
            out   <= in;
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

// ==== synchronizer.sv ====
`timescale 1ns/1ps

module synchronizer (
    input  logic clk,
    input  logic resetn,
    input  logic in,
    output logic out
);

    logic meta;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            meta <= 1'b0;
            out  <= 1'b0;
        end else begin
            meta <= in; // May go metastable
            out  <= meta;
        end
    end

endmodule

// ==== mic1_pkg.sv ====
package mic1_pkg;

    // Datapath word, signed for the ALU
    typedef logic signed [31:0] word_t;

    // Opcode in [15:8], signed immediate in [7:0]
    typedef logic [15:0] instr_t;

    typedef enum logic [7:0] {
        OP_NOP    = 8'h00,
        OP_BIPUSH = 8'h10, // Push sign-extended immediate
        OP_IADD   = 8'h60,
        OP_ISUB   = 8'h64, // a - b, b on top
        OP_DUP    = 8'h59,
        OP_POP    = 8'h57,
        OP_OUT    = 8'hB0, // Copy top of stack, no pop
        OP_GOTO   = 8'hA7, // Absolute target
        OP_HALT   = 8'hFF
    } opcode_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        STEP
    } run_state_t;

endpackage

// ==== mic1_cfg.svh ====
`ifndef MIC1_CFG_SVH
`define MIC1_CFG_SVH

// Stable cycles before a button level is accepted
`define DEBOUNCE_COUNT 511

// Operand stack entries
`define STACK_DEPTH 16

// Program words, sets the pc width
`define ROM_DEPTH 16

`endif
